/* Bender.yml */
package:
  name: sms_cart

sources:
  - logic/sms_cart_pkg.sv
  - logic/clock_enable_gen.sv
  - logic/cart_loader.sv
  - logic/cart_memory_arbiter.sv
  - logic/cheat_code_loader.sv
  - logic/backup_sector_sequencer.sv
  - logic/sms_cart_top.sv
  - target: test
    files:
      - tests/sms_cart_assertions.sv
      - tests/sms_cart_tb.sv

/* files.f */
logic/sms_cart_pkg.sv
logic/clock_enable_gen.sv
logic/cart_loader.sv
logic/cart_memory_arbiter.sv
logic/cheat_code_loader.sv
logic/backup_sector_sequencer.sv
logic/sms_cart_top.sv
tests/sms_cart_assertions.sv
tests/sms_cart_tb.sv

/* logic/backup_sector_sequencer.sv */
/*
  Walks BK_SECTORS sector requests to load or save the backup RAM image.
  BK_SECTORS must be a power of two and at least 2.
  Sector data moves outside this block while sd_ack is high.
*/
module backup_sector_sequencer #(
	parameter int BK_SECTORS = 64
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  cart_busy,
	input  logic                  bk_load,
	input  logic                  bk_save,
	input  logic                  img_mounted,
	input  logic                  img_readonly,
	input  logic                  img_present,
	input  logic                  sd_ack,
	output sms_cart_pkg::sd_lba_t sd_lba,
	output logic                  sd_rd,
	output logic                  sd_wr,
	output logic                  bk_busy,
	output logic                  core_reset
);
	localparam int SECT_W = $clog2(BK_SECTORS);

	typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_ACK} state_t;

	state_t state;
	logic   bk_ena;
	logic   loading;
	logic   old_busy;
	logic   old_load;
	logic   old_save;
	logic   auto_load;
	logic   load_start;
	logic   save_start;

	assign auto_load  = old_busy & ~cart_busy & img_present & bk_ena;  // End of download
	assign load_start = (bk_load & ~old_load & bk_ena) | auto_load;
	assign save_start = bk_save & ~old_save & bk_ena;
	assign bk_busy    = (state != ST_IDLE);

	// Save image must be mounted while the cartridge loads
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_ena   <= 1'b0;
			old_busy <= 1'b0;
			old_load <= 1'b0;
			old_save <= 1'b0;
		end else begin
			old_busy <= cart_busy;
			old_load <= bk_load;
			old_save <= bk_save;
			if (cart_busy & ~old_busy)
				bk_ena <= 1'b0;
			if (cart_busy & img_mounted & ~img_readonly)
				bk_ena <= 1'b1;
		end
	end

	// ========================================
	// Sector FSM
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= ST_IDLE;
			loading <= 1'b0;
			sd_rd   <= 1'b0;
			sd_wr   <= 1'b0;
			sd_lba  <= '0;
		end else begin
			case (state)
				ST_IDLE: if (load_start | save_start) begin
					state   <= ST_REQ;
					loading <= load_start;  // Load wins a tie
					sd_lba  <= '0;
					sd_rd   <= load_start;
					sd_wr   <= ~load_start;
				end
				ST_REQ: if (sd_ack) begin
					sd_rd <= 1'b0;
					sd_wr <= 1'b0;
					state <= ST_ACK;
				end
				ST_ACK: if (~sd_ack) begin  // Sector done
					if (&sd_lba[SECT_W-1:0]) begin
						state   <= ST_IDLE;
						loading <= 1'b0;
					end else begin
						sd_lba <= sd_lba + 1'b1;
						sd_rd  <= loading;
						sd_wr  <= ~loading;
						state  <= ST_REQ;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Core held while the image or its save data is arriving
	always_ff @(posedge clk_sys) begin
		core_reset <= reset | cart_busy | loading | auto_load;
	end

endmodule

/* logic/cart_loader.sv */
/*
  Splits host downloads into cheat and cartridge streams.
  Each cartridge byte raises ioctl_wait until the memory acknowledges it,
  so the host must not pulse ioctl_wr while ioctl_wait is high.
  hdr512 and gg_mode are valid only after a download has ended.
*/
module cart_loader #(
	parameter int CART_ADDR_W = 22
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      ioctl_download,
	input  sms_cart_pkg::ioctl_index_t ioctl_index,
	input  logic                      ioctl_wr,
	input  sms_cart_pkg::ioctl_addr_t ioctl_addr,
	input  sms_cart_pkg::byte_t       ioctl_dout,
	input  logic                      wr_ack,
	output logic                      ioctl_wait,
	output logic                      code_wr,
	output logic                      cart_busy,
	output logic                      gg_mode,
	output logic                      wr_req,
	output logic [CART_ADDR_W-1:0]    wr_addr,
	output sms_cart_pkg::byte_t       wr_data,
	output logic [CART_ADDR_W-1:0]    cart_mask,
	output logic [CART_ADDR_W-1:0]    cart_mask512,
	output logic                      hdr512
);
	import sms_cart_pkg::*;

	logic        code_dl;
	logic        cart_dl;
	logic        old_cart_dl;
	logic        cart_byte;
	ioctl_addr_t addr_less_hdr;

	assign code_dl       = ioctl_download & (ioctl_index == CHEAT_INDEX);
	assign cart_dl       = ioctl_download & (ioctl_index != CHEAT_INDEX);
	assign cart_byte     = ioctl_wr & cart_dl;
	assign code_wr       = ioctl_wr & code_dl;
	assign cart_busy     = cart_dl;
	assign addr_less_hdr = ioctl_addr - ioctl_addr_t'(HEADER_BYTES);

	// ========================================
	// Byte stream to memory
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_cart_dl <= 1'b0;
			ioctl_wait  <= 1'b0;
			wr_req      <= 1'b0;
			wr_addr     <= '0;
			hdr512      <= 1'b0;
			gg_mode     <= 1'b0;
		end else begin
			old_cart_dl <= cart_dl;
			if (cart_byte) begin
				ioctl_wait <= 1'b1;  // Held until the arbiter takes it
				wr_req     <= 1'b1;
			end else if (wr_ack) begin
				ioctl_wait <= 1'b0;
				wr_req     <= 1'b0;
				wr_addr    <= wr_addr + 1'b1;
			end
			if (cart_dl & ~old_cart_dl)
				wr_addr <= '0;  // New image starts at 0
			if (old_cart_dl & ~cart_dl) begin
				hdr512  <= ioctl_addr[9];  // Size is an odd multiple of 512
				gg_mode <= (ioctl_index[4:0] == GG_INDEX);
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cart_byte)
			wr_data <= ioctl_dout;
	end

	// Size masks, rebuilt as the addresses pass by
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_mask    <= '0;
			cart_mask512 <= '0;
		end else if (cart_byte) begin
			cart_mask <= (ioctl_addr == '0) ? '0 : cart_mask | ioctl_addr[CART_ADDR_W-1:0];
			if (ioctl_addr == ioctl_addr_t'(HEADER_BYTES))
				cart_mask512 <= '0;
			else
				cart_mask512 <= cart_mask512 | addr_less_hdr[CART_ADDR_W-1:0];
		end
	end

endmodule

/* logic/cart_memory_arbiter.sv */
/*
  Single-port cartridge byte memory shared by the loader and the console.
  A pending write always wins, so read latency is 2 cycles or more.
  Only one read may be outstanding. CART_ADDR_W must be at least 10.
*/
module cart_memory_arbiter #(
	parameter int CART_ADDR_W = 22
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   wr_req,
	input  logic [CART_ADDR_W-1:0] wr_addr,
	input  sms_cart_pkg::byte_t    wr_data,
	input  logic                   rom_rd,
	input  logic [CART_ADDR_W-1:0] rom_addr,
	input  logic [CART_ADDR_W-1:0] cart_mask,
	input  logic [CART_ADDR_W-1:0] cart_mask512,
	input  logic                   hdr512,
	output logic                   wr_ack,
	output sms_cart_pkg::byte_t    rom_data,
	output logic                   rom_rdy
);
	import sms_cart_pkg::*;

	byte_t mem [2**CART_ADDR_W];

	logic                   rd_pend;
	logic [CART_ADDR_W-1:0] rd_addr_q;
	logic [CART_ADDR_W-1:0] rd_addr_eff;
	logic [CART_ADDR_W-1:0] mem_addr;
	logic                   wr_grant;
	logic                   rd_grant;

	// wr_ack high means this request was already served
	assign wr_grant = wr_req & ~wr_ack;
	assign rd_grant = rd_pend & ~wr_grant;

	// Mirror small images, skip the copier header
	assign rd_addr_eff = hdr512 ?
		(rd_addr_q & cart_mask512) + CART_ADDR_W'(HEADER_BYTES) :
		rd_addr_q & cart_mask;

	assign mem_addr = wr_grant ? wr_addr : rd_addr_eff;

	// ========================================
	// Memory port
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (wr_grant)
			mem[mem_addr] <= wr_data;
		else if (rd_grant)
			rom_data <= mem[mem_addr];
		if (rom_rd)
			rd_addr_q <= rom_addr;
	end

	// ========================================
	// Grant tracking
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ack  <= 1'b0;
			rom_rdy <= 1'b0;
			rd_pend <= 1'b0;
		end else begin
			wr_ack  <= wr_grant;
			rom_rdy <= rd_grant;  // Same edge as rom_data
			if (rom_rd)
				rd_pend <= 1'b1;
			else if (rd_grant)
				rd_pend <= 1'b0;
		end
	end

endmodule

/* logic/cheat_code_loader.sv */
/*
  Builds one cheat code from a 16-byte download.
  Only the low four address bits select the byte, longer files overwrite.
  cheat_code is stable from cheat_valid until the next cheat download.
*/
module cheat_code_loader (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      code_wr,
	input  sms_cart_pkg::ioctl_addr_t ioctl_addr,
	input  sms_cart_pkg::byte_t       ioctl_dout,
	output sms_cart_pkg::cheat_code_t cheat_code,
	output logic                      cheat_valid
);
	logic [127:0] code_q;
	logic [6:0]   byte_lsb;

	// Field 0 (flags) sits at the top, bytes go in LSB first
	assign byte_lsb   = {~ioctl_addr[3:2], ioctl_addr[1:0], 3'b000};
	assign cheat_code = code_q;

	always_ff @(posedge clk_sys) begin
		if (code_wr)
			code_q[byte_lsb +: 8] <= ioctl_dout;
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= code_wr & (ioctl_addr[3:0] == 4'hf);  // Last byte in
	end

endmodule

/* logic/clock_enable_gen.sv */
/*
  Phased clock enables from one counter of CE_PERIOD cycles.
  Every strobe is high for one cycle, the cycle after its trigger count.
  ce_sp toggles every cycle.
*/
module clock_enable_gen (
	input  logic clk_sys,
	input  logic reset,
	output logic ce_cpu,
	output logic ce_vdp,
	output logic ce_pix,
	output logic ce_sp
);
	import sms_cart_pkg::*;

	localparam int CNT_W = $clog2(CE_PERIOD);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cnt    <= '0;
			ce_cpu <= 1'b0;
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			ce_sp  <= 1'b0;
		end else begin
			cnt    <= (cnt == CNT_W'(CE_PERIOD - 1)) ? '0 : cnt + 1'b1;
			ce_sp  <= cnt[0];
			ce_cpu <= 1'b0;
			ce_vdp <= 1'b0;  // Every 5
			ce_pix <= 1'b0;  // Every 10
			case (cnt)
				4, 14: ce_vdp <= 1'b1;
				9: begin
					ce_cpu <= 1'b1;
					ce_vdp <= 1'b1;
					ce_pix <= 1'b1;
				end
				19, 29: begin
					ce_vdp <= 1'b1;
					ce_pix <= 1'b1;
				end
				24: begin
					ce_cpu <= 1'b1;  // Late CPU phase, 15 after the first
					ce_vdp <= 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

/* logic/sms_cart_pkg.sv */
/*
  Shared types and constants for the cartridge support logic.
  Download addresses are 25 bits wide, as the host loader delivers them.
  A cheat code is 128 bits, flags in the top word down to replace in the bottom.
*/
package sms_cart_pkg;

	// ========================================
	// Download side
	// ========================================
	typedef logic [7:0] byte_t;

	localparam int IOCTL_ADDR_W = 25;

	typedef logic [IOCTL_ADDR_W-1:0] ioctl_addr_t;
	typedef logic [7:0] ioctl_index_t;

	localparam ioctl_index_t CHEAT_INDEX = 8'hff;  // All ones marks cheats
	localparam logic [4:0] GG_INDEX = 5'd2;        // Low five index bits
	localparam int HEADER_BYTES = 512;             // Copier header

	// ========================================
	// Console side
	// ========================================
	localparam int CE_PERIOD = 30;  // Strobe pattern length in clk_sys cycles

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef logic [31:0] sd_lba_t;

endpackage

/* logic/sms_cart_top.sv */
/*
  Cartridge and support logic around a Master System / Game Gear core.
  CART_ADDR_W sets the cartridge memory size, BK_SECTORS the backup image.
  rom_rd may be pulsed again only after rom_rdy.
*/
module sms_cart_top #(
	parameter int CART_ADDR_W = 22,
	parameter int BK_SECTORS  = 64
) (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       ioctl_download,
	input  sms_cart_pkg::ioctl_index_t ioctl_index,
	input  logic                       ioctl_wr,
	input  sms_cart_pkg::ioctl_addr_t  ioctl_addr,
	input  sms_cart_pkg::byte_t        ioctl_dout,
	input  logic                       rom_rd,
	input  logic [CART_ADDR_W-1:0]     rom_addr,
	input  logic                       bk_load,
	input  logic                       bk_save,
	input  logic                       img_mounted,
	input  logic                       img_readonly,
	input  logic                       img_present,
	input  logic                       sd_ack,
	output logic                       ioctl_wait,
	output sms_cart_pkg::byte_t        rom_data,
	output logic                       rom_rdy,
	output logic                       gg_mode,
	output sms_cart_pkg::cheat_code_t  cheat_code,
	output logic                       cheat_valid,
	output logic                       ce_cpu,
	output logic                       ce_vdp,
	output logic                       ce_pix,
	output logic                       ce_sp,
	output sms_cart_pkg::sd_lba_t      sd_lba,
	output logic                       sd_rd,
	output logic                       sd_wr,
	output logic                       bk_busy,
	output logic                       core_reset
);
	import sms_cart_pkg::*;

	logic                   code_wr;
	logic                   cart_busy;
	logic                   wr_req;
	logic                   wr_ack;
	logic [CART_ADDR_W-1:0] wr_addr;
	byte_t                  wr_data;
	logic [CART_ADDR_W-1:0] cart_mask;
	logic [CART_ADDR_W-1:0] cart_mask512;
	logic                   hdr512;

	clock_enable_gen i_clock_enable_gen (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ce_cpu  (ce_cpu),
		.ce_vdp  (ce_vdp),
		.ce_pix  (ce_pix),
		.ce_sp   (ce_sp)
	);

	cart_loader #(.CART_ADDR_W(CART_ADDR_W)) i_cart_loader (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.wr_ack         (wr_ack),
		.ioctl_wait     (ioctl_wait),
		.code_wr        (code_wr),
		.cart_busy      (cart_busy),
		.gg_mode        (gg_mode),
		.wr_req         (wr_req),
		.wr_addr        (wr_addr),
		.wr_data        (wr_data),
		.cart_mask      (cart_mask),
		.cart_mask512   (cart_mask512),
		.hdr512         (hdr512)
	);

	cart_memory_arbiter #(.CART_ADDR_W(CART_ADDR_W)) i_cart_memory_arbiter (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.wr_req       (wr_req),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.rom_rd       (rom_rd),
		.rom_addr     (rom_addr),
		.cart_mask    (cart_mask),
		.cart_mask512 (cart_mask512),
		.hdr512       (hdr512),
		.wr_ack       (wr_ack),
		.rom_data     (rom_data),
		.rom_rdy      (rom_rdy)
	);

	cheat_code_loader i_cheat_code_loader (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.code_wr     (code_wr),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid)
	);

	backup_sector_sequencer #(.BK_SECTORS(BK_SECTORS)) i_backup_sector_sequencer (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cart_busy    (cart_busy),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_present  (img_present),
		.sd_ack       (sd_ack),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.bk_busy      (bk_busy),
		.core_reset   (core_reset)
	);

endmodule

/* tests/sms_cart_assertions.sv */
/*
  Handshake checks on the cartridge memory port and the SD sector port.
  Bound into sms_cart_top, where both interfaces are visible.
  Reads are expected back within 8 cycles.
*/
module sms_cart_assertions (
	input logic clk_sys,
	input logic reset,
	input logic wr_req,
	input logic wr_ack,
	input logic rom_rd,
	input logic rom_rdy,
	input logic sd_rd,
	input logic sd_wr,
	input logic sd_ack
);
	timeunit 1ns;
	timeprecision 1ps;

	int   fail_count = 0;
	logic rd_open;  // A read is waiting for rom_rdy

	always_ff @(posedge clk_sys) begin
		if (reset)
			rd_open <= 1'b0;
		else if (rom_rd)
			rd_open <= 1'b1;
		else if (rom_rdy)
			rd_open <= 1'b0;
	end

	// ========================================
	// Memory port
	// ========================================
	a_wr_ack_after_req: assert property (@(posedge clk_sys) disable iff (reset)
		wr_ack |-> $past(wr_req))
		else begin
			$error("wr_ack without a preceding wr_req");
			fail_count++;
		end

	a_rdy_after_rd: assert property (@(posedge clk_sys) disable iff (reset)
		rom_rd |-> ##[2:8] rom_rdy)
		else begin
			$error("rom_rd not answered by rom_rdy");
			fail_count++;
		end

	a_rdy_only_when_open: assert property (@(posedge clk_sys) disable iff (reset)
		rom_rdy |-> rd_open)
		else begin
			$error("rom_rdy without an open read");
			fail_count++;
		end

	// ========================================
	// SD port
	// ========================================
	a_sd_one_dir: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr))
		else begin
			$error("sd_rd and sd_wr high together");
			fail_count++;
		end

	a_sd_rd_held: assert property (@(posedge clk_sys) disable iff (reset)
		(sd_rd && !sd_ack) |=> sd_rd)
		else begin
			$error("sd_rd dropped before sd_ack");
			fail_count++;
		end

	a_sd_wr_held: assert property (@(posedge clk_sys) disable iff (reset)
		(sd_wr && !sd_ack) |=> sd_wr)
		else begin
			$error("sd_wr dropped before sd_ack");
			fail_count++;
		end

endmodule

bind sms_cart_top sms_cart_assertions i_assertions (
	.clk_sys (clk_sys),
	.reset   (reset),
	.wr_req  (wr_req),
	.wr_ack  (wr_ack),
	.rom_rd  (rom_rd),
	.rom_rdy (rom_rdy),
	.sd_rd   (sd_rd),
	.sd_wr   (sd_wr),
	.sd_ack  (sd_ack)
);

/* tests/sms_cart_tb.sv */
/*
  Directed testbench for sms_cart_top with a 4 KiB cartridge memory.
  Inputs change on the falling clock edge, outputs are sampled there too.
  The SD side is a reactive model that answers every sector request.
  Stops at the first error.
*/
module sms_cart_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import sms_cart_pkg::*;

	localparam int AW         = 12;
	localparam int MEM_SIZE   = 2**AW;
	localparam int BK_SECTORS = 64;
	localparam int TIMEOUT    = 200;  // Cycles per handshake wait

	logic          clk_sys;
	logic          reset;
	logic          ioctl_download;
	ioctl_index_t  ioctl_index;
	logic          ioctl_wr;
	ioctl_addr_t   ioctl_addr;
	byte_t         ioctl_dout;
	logic          rom_rd;
	logic [AW-1:0] rom_addr;
	logic          bk_load, bk_save;
	logic          img_mounted, img_readonly, img_present;
	logic          sd_ack;
	logic          ioctl_wait;
	byte_t         rom_data;
	logic          rom_rdy;
	logic          gg_mode;
	cheat_code_t   cheat_code;
	logic          cheat_valid;
	logic          ce_cpu, ce_vdp, ce_pix, ce_sp;
	sd_lba_t       sd_lba;
	logic          sd_rd, sd_wr;
	logic          bk_busy;
	logic          core_reset;

	byte_t mem_model [MEM_SIZE];  // Bytes in download order
	byte_t cheat_bytes [16];
	int    cheat_pulses = 0;

	sms_cart_top #(
		.CART_ADDR_W (AW),
		.BK_SECTORS  (BK_SECTORS)
	) i_sms_cart_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	always @(negedge clk_sys) begin
		if (cheat_valid)
			cheat_pulses++;
	end

	// SD card model, acks each request after a short random delay
	initial begin
		sd_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if ((sd_rd || sd_wr) && !sd_ack) begin
				repeat (1 + $urandom % 4) @(negedge clk_sys);
				sd_ack = 1'b1;
				repeat (2 + $urandom % 3) @(negedge clk_sys);
				sd_ack = 1'b0;
			end
		end
	end

	// ========================================
	// Reporting and compares
	// ========================================
	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_byte(input byte_t got, input byte_t exp, input string what);
		if (got !== exp)
			stop_with_error($sformatf("Fail at %0t ns: %s is %02h, expected %02h",
				$time, what, got, exp));
	endtask

	task automatic check_code(input cheat_code_t got, input cheat_code_t exp);
		if (got !== exp)
			stop_with_error($sformatf("Fail at %0t ns: cheat_code is %032h, expected %032h",
				$time, got, exp));
	endtask

	task automatic check_lba(input sd_lba_t got, input sd_lba_t exp, input string what);
		if (got !== exp)
			stop_with_error($sformatf("Fail at %0t ns: %s is %0d, expected %0d",
				$time, what, got, exp));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			stop_with_error($sformatf("Fail at %0t ns: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp)
			stop_with_error($sformatf("Fail at %0t ns: %s is %0d, expected %0d",
				$time, what, got, exp));
	endtask

	// ========================================
	// Host side drivers
	// ========================================
	task automatic begin_download(input ioctl_index_t index);
		@(negedge clk_sys);
		ioctl_index    = index;
		ioctl_addr     = '0;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic send_byte(input int addr, input byte_t data);
		int guard;
		ioctl_addr = ioctl_addr_t'(addr);
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		@(negedge clk_sys);
		ioctl_wr   = 1'b0;
		ioctl_addr = ioctl_addr_t'(addr + 1);  // Host address runs one ahead
		guard = 0;
		while (ioctl_wait) begin
			if (guard == TIMEOUT)
				stop_with_error("Timed out waiting for ioctl_wait to fall");
			guard++;
			@(negedge clk_sys);
		end
	endtask

	task automatic end_download();
		ioctl_download = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic download_image(input ioctl_index_t index, input int count);
		byte_t data;
		begin_download(index);
		for (int i = 0; i < count; i++) begin
			data = byte_t'($urandom);
			if (index == CHEAT_INDEX)
				cheat_bytes[i % 16] = data;
			else
				mem_model[i % MEM_SIZE] = data;
			send_byte(i, data);
		end
		end_download();
	endtask

	task automatic read_rom(input logic [AW-1:0] addr, output byte_t data);
		int guard;
		rom_addr = addr;
		rom_rd   = 1'b1;
		@(negedge clk_sys);
		rom_rd = 1'b0;
		guard  = 0;
		@(negedge clk_sys);
		while (!rom_rdy) begin
			if (guard == TIMEOUT)
				stop_with_error("Timed out waiting for rom_rdy");
			guard++;
			@(negedge clk_sys);
		end
		data = rom_data;
	endtask

	// Images mirror by their size and header images skip the first 512 bytes
	function automatic logic [AW-1:0] expected_addr(input logic [AW-1:0] a, input int size,
		input logic hdr);
		if (hdr)
			return AW'(HEADER_BYTES + (a % (size - HEADER_BYTES)));
		return AW'(a % size);
	endfunction

	task automatic check_reads(input int size, input logic hdr);
		logic [AW-1:0] a;
		byte_t         got;
		for (int n = 0; n < 64; n++) begin
			a = AW'($urandom);
			read_rom(a, got);
			check_byte(got, mem_model[expected_addr(a, size, hdr)],
				$sformatf("rom_data at %03h", a));
		end
	endtask

	task automatic run_sectors(input logic load);
		int   guard;
		int   sectors;
		logic prev_req;
		guard = 0;
		while (!bk_busy) begin
			if (guard == TIMEOUT)
				stop_with_error("Timed out waiting for bk_busy to rise");
			guard++;
			@(negedge clk_sys);
		end
		sectors  = 0;
		prev_req = 1'b0;
		guard    = 0;
		while (bk_busy) begin
			if ((sd_rd || sd_wr) && !prev_req) begin  // New sector request
				check_lba(sd_lba, sd_lba_t'(sectors), "sd_lba");
				check_bit(sd_rd, load, "sd_rd");
				check_bit(sd_wr, !load, "sd_wr");
				sectors++;
			end
			if (load)
				check_bit(core_reset, 1'b1, "core_reset while loading");
			prev_req = sd_rd || sd_wr;
			if (guard == BK_SECTORS * 40)
				stop_with_error("Timed out waiting for bk_busy to fall");
			guard++;
			@(negedge clk_sys);
		end
		check_count(sectors, BK_SECTORS, "sector count");
	endtask

	// ========================================
	// Directed tests
	// ========================================
	task automatic check_reset_state();
		check_bit(core_reset, 1'b1, "core_reset in reset");
		check_bit(ioctl_wait, 1'b0, "ioctl_wait in reset");
		check_bit(rom_rdy, 1'b0, "rom_rdy in reset");
		check_bit(cheat_valid, 1'b0, "cheat_valid in reset");
		check_bit(sd_rd | sd_wr, 1'b0, "sd request in reset");
		check_bit(bk_busy, 1'b0, "bk_busy in reset");
	endtask

	task automatic test_clock_enables();
		int   last_vdp, last_pix, last_cpu;
		int   n_vdp, n_pix, n_cpu;
		logic prev_sp;
		last_vdp = -1;
		last_pix = -1;
		last_cpu = -1;
		n_vdp = 0;
		n_pix = 0;
		n_cpu = 0;
		@(negedge clk_sys);
		prev_sp = ce_sp;
		for (int c = 0; c < 60; c++) begin
			@(negedge clk_sys);
			check_bit(ce_sp, !prev_sp, "ce_sp");
			prev_sp = ce_sp;
			if (ce_vdp) begin
				if (last_vdp >= 0)
					check_count(c - last_vdp, 5, "ce_vdp interval");
				last_vdp = c;
				n_vdp++;
			end
			if (ce_pix) begin
				if (last_pix >= 0)
					check_count(c - last_pix, 10, "ce_pix interval");
				last_pix = c;
				n_pix++;
			end
			if (ce_cpu) begin
				if (last_cpu >= 0)
					check_count(c - last_cpu, 15, "ce_cpu interval");
				check_bit(ce_vdp, 1'b1, "ce_vdp with ce_cpu");
				last_cpu = c;
				n_cpu++;
			end
		end
		check_count(n_vdp, 12, "ce_vdp strobes");
		check_count(n_pix, 6, "ce_pix strobes");
		check_count(n_cpu, 4, "ce_cpu strobes");
	endtask

	task automatic test_cart_download();
		download_image(8'd1, 1024);
		check_bit(gg_mode, 1'b0, "gg_mode");
		check_reads(1024, 1'b0);
	endtask

	task automatic test_header_skip();
		download_image(8'd2, 1536);  // Odd multiple of 512, so a header
		check_bit(gg_mode, 1'b1, "gg_mode");
		check_reads(1536, 1'b1);
	endtask

	task automatic test_cheat_code();
		cheat_code_t exp;
		int          start;
		int          guard;
		start = cheat_pulses;
		download_image(CHEAT_INDEX, 16);
		guard = 0;
		while (cheat_pulses == start) begin
			if (guard == TIMEOUT)
				stop_with_error("Timed out waiting for cheat_valid");
			guard++;
			@(negedge clk_sys);
		end
		repeat (4) @(negedge clk_sys);
		check_count(cheat_pulses - start, 1, "cheat_valid pulses");
		exp.flags   = {cheat_bytes[3], cheat_bytes[2], cheat_bytes[1], cheat_bytes[0]};
		exp.address = {cheat_bytes[7], cheat_bytes[6], cheat_bytes[5], cheat_bytes[4]};
		exp.compare = {cheat_bytes[11], cheat_bytes[10], cheat_bytes[9], cheat_bytes[8]};
		exp.replace = {cheat_bytes[15], cheat_bytes[14], cheat_bytes[13], cheat_bytes[12]};
		check_code(cheat_code, exp);
	endtask

	task automatic test_backup_transfers();
		int guard;
		img_mounted  = 1'b1;
		img_readonly = 1'b0;
		img_present  = 1'b1;
		begin_download(8'd1);
		for (int i = 0; i < 8; i++)
			send_byte(i, byte_t'($urandom));
		check_bit(core_reset, 1'b1, "core_reset during download");
		end_download();
		run_sectors(1'b1);  // Automatic load
		guard = 0;
		while (core_reset) begin
			if (guard == TIMEOUT)
				stop_with_error("Timed out waiting for core_reset to fall");
			guard++;
			@(negedge clk_sys);
		end
		bk_save = 1'b1;
		@(negedge clk_sys);
		bk_save = 1'b0;
		run_sectors(1'b0);
	endtask

	initial begin
		void'($urandom(73));
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		rom_rd         = 1'b0;
		rom_addr       = '0;
		bk_load        = 1'b0;
		bk_save        = 1'b0;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		img_present    = 1'b0;
		repeat (5) @(negedge clk_sys);
		check_reset_state();
		reset = 1'b0;

		test_clock_enables();
		test_cart_download();
		test_header_skip();
		test_cheat_code();
		test_backup_transfers();

		if (i_sms_cart_top.i_assertions.fail_count == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			stop_with_error("Protocol assertions failed during the run");
		end
	end

endmodule
